// File: cpuPkg.sv
package cpuPkg;

   // Opcode lives in instr[15:12], unused codes run as NOP
   typedef enum logic [3:0] {
      opNop  = 4'd0,
      opAdd  = 4'd1,
      opSub  = 4'd2,
      opAnd  = 4'd3,
      opXor  = 4'd4,
      opAddi = 4'd5,
      opLd   = 4'd6,
      opSt   = 4'd7,
      opBeqz = 4'd8,
      opHalt = 4'd15
   } opcodeE;

   typedef struct packed {
      logic        valid;
      logic [5:0]  pc;
      logic [15:0] instr;
   } ifIdT;

   typedef struct packed {
      logic        valid;
      opcodeE      op;
      logic [2:0]  rd;
      logic        regWrite;
      logic [15:0] opA;
      logic [15:0] opB;
      logic [15:0] storeData;
      logic [15:0] imm;
   } idExT;

   typedef struct packed {
      logic        valid;
      opcodeE      op;
      logic [2:0]  rd;
      logic        regWrite;
      logic [15:0] result;
      logic [15:0] storeData;
   } exMemT;

   typedef struct packed {
      logic        valid;
      logic        halt;
      logic [2:0]  rd;
      logic        regWrite;
      logic [15:0] wbData;
   } memWbT;

endpackage

// File: decodeStage.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module decodeStage import cpuPkg::*; (
   input  logic        clk,
   input  logic        rstN,
   input  logic        runEn,
   input  ifIdT        ifId,
   input  idExT        idExQ,
   input  exMemT       exMemQ,
   input  memWbT       memWb,
   input  logic [2:0]  dbgRegIdx,
   output logic [15:0] dbgRegData,
   output logic        stall,
   output logic        branchTaken,
   output logic        haltSeen,
   output logic [5:0]  branchTarget,
   output idExT        idEx
);

   logic [15:0] regs [`PROC_NUM_REGS];
   logic [2:0]  rd, rs, rt;
   logic [15:0] imm, rsVal, rtVal, rdVal;
   opcodeE      op;
   logic        aluOp, useRs, useRt, useRd, writesReg;
   logic        wbWrite, haltNow, haltLatched;

   // Older writer still in EX or MEM
   function automatic logic busy(input logic [2:0] idx, input idExT ex, input exMemT mem);
      return (ex.valid && ex.regWrite && ex.rd == idx) ||
             (mem.valid && mem.regWrite && mem.rd == idx);
   endfunction

   assign rd  = ifId.instr[11:9];
   assign rs  = ifId.instr[8:6];
   assign rt  = ifId.instr[5:3];
   assign imm = {{10{ifId.instr[5]}}, ifId.instr[5:0]};

   always_comb begin
      case (ifId.instr[15:12])
         opAdd, opSub, opAnd, opXor, opAddi, opLd, opSt, opBeqz, opHalt:
            op = opcodeE'(ifId.instr[15:12]);
         default: op = opNop;
      endcase
   end

   assign aluOp     = (op == opAdd) || (op == opSub) || (op == opAnd) || (op == opXor);
   assign useRs     = aluOp || (op == opAddi) || (op == opLd) || (op == opSt) || (op == opBeqz);
   assign useRt     = aluOp;
   // ST reads rd as its store data
   assign useRd     = (op == opSt);
   assign writesReg = aluOp || (op == opAddi) || (op == opLd);

   assign stall = ifId.valid && ((useRs && busy(rs, idExQ, exMemQ)) ||
                                 (useRt && busy(rt, idExQ, exMemQ)) ||
                                 (useRd && busy(rd, idExQ, exMemQ)));

   // Write-through so a same-cycle writeback is seen here
   assign wbWrite = memWb.valid && memWb.regWrite;
   assign rsVal   = (wbWrite && memWb.rd == rs) ? memWb.wbData : regs[rs];
   assign rtVal   = (wbWrite && memWb.rd == rt) ? memWb.wbData : regs[rt];
   assign rdVal   = (wbWrite && memWb.rd == rd) ? memWb.wbData : regs[rd];

   assign dbgRegData = regs[dbgRegIdx];

   assign branchTaken  = ifId.valid && !stall && (op == opBeqz) && (rsVal == 16'd0);
   assign branchTarget = ifId.pc + 6'd1 + imm[5:0];
   assign haltNow      = ifId.valid && (op == opHalt);
   assign haltSeen     = haltNow || haltLatched;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < `PROC_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wbWrite) begin
         regs[memWb.rd] <= memWb.wbData;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         idEx        <= '0;
         haltLatched <= 1'b0;
      end else begin
         // Fetch stays stopped after HALT until the next start
         haltLatched <= runEn && (haltLatched || haltNow);
         if (!runEn || stall || !ifId.valid) begin
            idEx <= '0;
         end else begin
            idEx.valid     <= 1'b1;
            idEx.op        <= op;
            idEx.rd        <= rd;
            idEx.regWrite  <= writesReg;
            idEx.opA       <= rsVal;
            idEx.opB       <= rtVal;
            idEx.storeData <= rdVal;
            idEx.imm       <= imm;
         end
      end
   end

endmodule

// File: executeStage.sv
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
   input  logic  clk,
   input  logic  rstN,
   input  logic  runEn,
   input  idExT  idEx,
   output exMemT exMem
);

   logic [15:0] aluOut;

   always_comb begin
      case (idEx.op)
         opAdd: aluOut = idEx.opA + idEx.opB;
         opSub: aluOut = idEx.opA - idEx.opB;
         opAnd: aluOut = idEx.opA & idEx.opB;
         opXor: aluOut = idEx.opA ^ idEx.opB;
         // Load/store address uses the same base plus offset sum
         opAddi, opLd, opSt: aluOut = idEx.opA + idEx.imm;
         default: aluOut = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         exMem <= '0;
      end else if (!runEn) begin
         exMem <= '0;
      end else begin
         exMem.valid     <= idEx.valid;
         exMem.op        <= idEx.op;
         exMem.rd        <= idEx.rd;
         exMem.regWrite  <= idEx.regWrite;
         exMem.result    <= aluOut;
         exMem.storeData <= idEx.storeData;
      end
   end

endmodule

// File: fetchStage.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module fetchStage import cpuPkg::*; (
   input  logic        clk,
   input  logic        rstN,
   input  logic        runEn,
   input  logic        stall,
   input  logic        branchTaken,
   input  logic        haltSeen,
   input  logic [5:0]  branchTarget,
   input  logic        imemWe,
   input  logic [5:0]  imemIdx,
   input  logic [15:0] imemWdata,
   output ifIdT        ifId
);

   logic [15:0] imem [`PROC_IMEM_DEPTH];
   logic [5:0]  pc;

   // Host loads the program over APB while the core is stopped
   always_ff @(posedge clk) begin
      if (imemWe) begin
         imem[imemIdx] <= imemWdata;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc   <= '0;
         ifId <= '0;
      end else if (!runEn) begin
         pc   <= '0;
         ifId <= '0;
      end else if (!stall) begin
         if (branchTaken) begin
            // Word fetched behind the branch is dropped
            pc         <= branchTarget;
            ifId.valid <= 1'b0;
         end else if (haltSeen) begin
            ifId.valid <= 1'b0;
         end else begin
            pc         <= pc + 6'd1;
            ifId.valid <= 1'b1;
            ifId.pc    <= pc;
            ifId.instr <= imem[pc];
         end
      end
   end

endmodule

// File: flist.f
+incdir+.
cpuPkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
procCtrlRegs.sv
proc.sv
procChecker.sv
tbProc.sv

// File: memoryStage.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module memoryStage import cpuPkg::*; (
   input  logic        clk,
   input  logic        rstN,
   input  logic        runEn,
   input  exMemT       exMem,
   input  logic [5:0]  dbgMemIdx,
   output logic [15:0] dbgMemData,
   output memWbT       memWb
);

   logic [15:0] dmem [`PROC_DMEM_DEPTH];
   logic [5:0]  addr;
   logic [15:0] loadData;

   // Word address, upper bits of the sum wrap away
   assign addr       = exMem.result[5:0];
   assign loadData   = dmem[addr];
   assign dbgMemData = dmem[dbgMemIdx];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < `PROC_DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (exMem.valid && exMem.op == opSt) begin
         dmem[addr] <= exMem.storeData;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         memWb <= '0;
      end else if (!runEn) begin
         memWb <= '0;
      end else begin
         memWb.valid    <= exMem.valid;
         memWb.halt     <= exMem.valid && exMem.op == opHalt;
         memWb.rd       <= exMem.rd;
         memWb.regWrite <= exMem.regWrite;
         memWb.wbData   <= (exMem.op == opLd) ? loadData : exMem.result;
      end
   end

endmodule

// File: proc.sv
`timescale 1ns/1ps

module proc import cpuPkg::*; (
   input  logic        clk,
   input  logic        rstN,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [11:0] paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr
);

   // Pipeline registers between stages
   ifIdT  ifId;
   idExT  idEx;
   exMemT exMem;
   memWbT memWb;

   logic        runEn;
   logic        stall, branchTaken, haltSeen;
   logic [5:0]  branchTarget;
   logic        imemWe;
   logic [5:0]  imemIdx;
   logic [15:0] imemWdata;
   logic [2:0]  dbgRegIdx;
   logic [15:0] dbgRegData;
   logic [5:0]  dbgMemIdx;
   logic [15:0] dbgMemData;

   fetchStage fet (
      .clk(clk), .rstN(rstN), .runEn(runEn),
      .stall(stall), .branchTaken(branchTaken), .haltSeen(haltSeen),
      .branchTarget(branchTarget),
      .imemWe(imemWe), .imemIdx(imemIdx), .imemWdata(imemWdata),
      .ifId(ifId)
   );

   decodeStage dec (
      .clk(clk), .rstN(rstN), .runEn(runEn),
      .ifId(ifId), .idExQ(idEx), .exMemQ(exMem), .memWb(memWb),
      .dbgRegIdx(dbgRegIdx), .dbgRegData(dbgRegData),
      .stall(stall), .branchTaken(branchTaken), .haltSeen(haltSeen),
      .branchTarget(branchTarget), .idEx(idEx)
   );

   executeStage exe (.clk(clk), .rstN(rstN), .runEn(runEn), .idEx(idEx), .exMem(exMem));

   memoryStage mem (
      .clk(clk), .rstN(rstN), .runEn(runEn), .exMem(exMem),
      .dbgMemIdx(dbgMemIdx), .dbgMemData(dbgMemData), .memWb(memWb)
   );

   // Host side, also watches retirement for the halt
   procCtrlRegs ctrl (
      .clk(clk), .rstN(rstN),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
      .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .wbValid(memWb.valid), .wbHalt(memWb.halt), .runEn(runEn),
      .imemWe(imemWe), .imemIdx(imemIdx), .imemWdata(imemWdata),
      .dbgRegIdx(dbgRegIdx), .dbgRegData(dbgRegData),
      .dbgMemIdx(dbgMemIdx), .dbgMemData(dbgMemData)
   );

endmodule

// File: procChecker.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module procChecker import cpuPkg::*; (
   input  logic        clk,
   input  logic        rstN,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [11:0] paddr,
   input  logic [31:0] pwdata,
   input  logic [31:0] prdata,
   input  logic        pready,
   input  logic        pslverr,
   output int          errors,
   output int          checks
);

   // Branches only go forward, so a program ends well within this
   localparam int MaxSteps = 4 * `PROC_IMEM_DEPTH;

   logic [15:0] imemM [`PROC_IMEM_DEPTH];
   logic [15:0] regM [`PROC_NUM_REGS];
   logic [15:0] dmemM [`PROC_DMEM_DEPTH];
   logic [15:0] retiredM;
   // Set from a start until a STATUS read shows the halt
   logic        running, halted;
   logic        isCtrl, isStatus, isRetired, isImem, isRegs, isDmem, isMapped;
   logic [5:0]  slot;
   logic [31:0] expData;
   logic        expErr, useData;

   assign slot      = paddr[7:2];
   assign isCtrl    = paddr == `PROC_ADDR_CTRL;
   assign isStatus  = paddr == `PROC_ADDR_STATUS;
   assign isRetired = paddr == `PROC_ADDR_RETIRED;
   // Windows at 0x100, 0x200 and 0x300, word slots only
   assign isImem    = paddr[1:0] == 2'b00 && paddr[11:8] == 4'h1;
   assign isRegs    = paddr[1:0] == 2'b00 && paddr[11:8] == 4'h2 && slot < 6'(`PROC_NUM_REGS);
   assign isDmem    = paddr[1:0] == 2'b00 && paddr[11:8] == 4'h3;
   assign isMapped  = isCtrl || isStatus || isRetired || isImem || isRegs || isDmem;

   // Architectural execution of the loaded program, one instruction per step
   task automatic runProgram();
      logic [5:0]  pc;
      logic [15:0] ins, imm, sum;
      logic [2:0]  rd, rs, rt;
      logic        done;
      int          steps;
      pc       = '0;
      done     = 1'b0;
      steps    = 0;
      retiredM = '0;
      while (!done && steps < MaxSteps) begin
         ins = imemM[pc];
         rd  = ins[11:9];
         rs  = ins[8:6];
         rt  = ins[5:3];
         imm = {{10{ins[5]}}, ins[5:0]};
         sum = regM[rs] + imm;
         pc  = pc + 6'd1;
         case (ins[15:12])
            opAdd: regM[rd] = regM[rs] + regM[rt];
            opSub: regM[rd] = regM[rs] - regM[rt];
            opAnd: regM[rd] = regM[rs] & regM[rt];
            opXor: regM[rd] = regM[rs] ^ regM[rt];
            opAddi: regM[rd] = sum;
            opLd: regM[rd] = dmemM[sum[5:0]];
            opSt: dmemM[sum[5:0]] = regM[rd];
            opBeqz: if (regM[rs] == 16'd0) pc = pc + imm[5:0];
            opHalt: done = 1'b1;
            default: ;
         endcase
         retiredM = retiredM + 16'd1;
         steps++;
      end
      if (!done) begin
         errors++;
         $display("Reference model ran %0d steps without reaching HALT", steps);
      end
   endtask

   always @(negedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `PROC_NUM_REGS; i++) begin
            regM[i] = '0;
         end
         for (int i = 0; i < `PROC_DMEM_DEPTH; i++) begin
            dmemM[i] = '0;
            imemM[i] = '0;
         end
         retiredM = '0;
         running  = 1'b0;
         halted   = 1'b0;
         errors   = 0;
         checks   = 0;
      end else if (psel && penable) begin
         checks++;
         expErr  = !isMapped || (running && (pwrite ? isImem : (isRegs || isDmem)));
         useData = !pwrite && !expErr;
         expData = '0;
         if (useData) begin
            if (isCtrl) expData = {31'd0, running};
            else if (isStatus) begin
               // A halted reply ends the run in the model too
               if (running && prdata == 32'd1) begin
                  running = 1'b0;
                  halted  = 1'b1;
               end
               expData = {30'd0, running, halted};
            end else if (isRetired) begin
               useData = !running;
               expData = {16'd0, retiredM};
            end else if (isRegs) expData = {16'd0, regM[slot[2:0]]};
            else if (isDmem) expData = {16'd0, dmemM[slot]};
            else useData = 1'b0;
         end
         if (pslverr !== expErr || (useData && prdata !== expData)) begin
            errors++;
            $display("error at %0t: %s 0x%03h gave data 0x%08h err %0b, expected 0x%08h err %0b",
               $time, pwrite ? "write" : "read", paddr, prdata, pslverr, expData, expErr);
         end
         // APB never waits, every access cycle completes
         if (pready !== 1'b1) begin
            errors++;
            $display("error at %0t: pready low in the access cycle to 0x%03h", $time, paddr);
         end
         if (pwrite && !expErr) begin
            if (isImem) imemM[slot] = pwdata[15:0];
            if (isCtrl && pwdata[0]) begin
               running = 1'b1;
               halted  = 1'b0;
               runProgram();
            end
         end
      end
   end

endmodule

// File: procCtrlRegs.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module procCtrlRegs (
   input  logic        clk,
   input  logic        rstN,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [11:0] paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   input  logic        wbValid,
   input  logic        wbHalt,
   output logic        runEn,
   output logic        imemWe,
   output logic [5:0]  imemIdx,
   output logic [15:0] imemWdata,
   output logic [2:0]  dbgRegIdx,
   input  logic [15:0] dbgRegData,
   output logic [5:0]  dbgMemIdx,
   input  logic [15:0] dbgMemData
);

   logic        access, rdAcc, wrAcc, mapped, busyErr;
   logic        hitCtrl, hitStatus, hitRetired, hitImem, hitRegs, hitDmem;
   logic        halted;
   logic [15:0] retired;
   logic [5:0]  slot;

   assign access = psel && penable;
   assign rdAcc  = access && !pwrite;
   assign wrAcc  = access && pwrite;
   assign slot   = paddr[7:2];

   assign hitCtrl    = paddr == `PROC_ADDR_CTRL;
   assign hitStatus  = paddr == `PROC_ADDR_STATUS;
   assign hitRetired = paddr == `PROC_ADDR_RETIRED;
   // Window slots are word aligned
   assign hitImem    = (paddr & 12'hF03) == `PROC_BASE_IMEM;
   assign hitRegs    = (paddr & 12'hF03) == `PROC_BASE_REGS && slot < `PROC_NUM_REGS;
   assign hitDmem    = (paddr & 12'hF03) == `PROC_BASE_DMEM;
   assign mapped     = hitCtrl || hitStatus || hitRetired || hitImem || hitRegs || hitDmem;

   // Core-owned state is off limits during a run
   assign busyErr = runEn && ((pwrite && hitImem) || (!pwrite && (hitRegs || hitDmem)));
   assign pslverr = access && (!mapped || busyErr);
   assign pready  = 1'b1;

   assign imemWe    = wrAcc && hitImem && !runEn;
   assign imemIdx   = slot;
   assign imemWdata = pwdata[15:0];
   assign dbgRegIdx = slot[2:0];
   assign dbgMemIdx = slot;

   always_comb begin
      prdata = '0;
      if (rdAcc && !pslverr) begin
         if (hitCtrl) prdata = {31'd0, runEn};
         else if (hitStatus) prdata = {30'd0, runEn, halted};
         else if (hitRetired) prdata = {16'd0, retired};
         else if (hitRegs) prdata = {16'd0, dbgRegData};
         else if (hitDmem) prdata = {16'd0, dbgMemData};
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         runEn   <= 1'b0;
         halted  <= 1'b0;
         retired <= '0;
      end else if (wrAcc && hitCtrl && pwdata[0]) begin
         runEn   <= 1'b1;
         halted  <= 1'b0;
         retired <= '0;
      end else if (wbValid) begin
         // HALT itself counts as retired
         retired <= retired + 16'd1;
         if (wbHalt) begin
            runEn  <= 1'b0;
            halted <= 1'b1;
         end
      end
   end

endmodule

// File: proc_defs.svh
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

// Memory sizes in 16-bit words
`define PROC_IMEM_DEPTH 64
`define PROC_DMEM_DEPTH 64

// General register count
`define PROC_NUM_REGS 8

// APB register map, byte addresses
`define PROC_ADDR_CTRL    12'h000
`define PROC_ADDR_STATUS  12'h004
`define PROC_ADDR_RETIRED 12'h008

// Access windows, one 16-bit word per 4-byte slot
`define PROC_BASE_IMEM 12'h100
`define PROC_BASE_REGS 12'h200
`define PROC_BASE_DMEM 12'h300

`endif

// File: runSim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f flist.f --top-module tbProc -o simProc \
   && ./obj_dir/simProc | tee /dev/stderr | grep -F "Simulation completed successfully" > /dev/null \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }
exit 0

// File: tbProc.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module tbProc import cpuPkg::*; ();

   localparam int ProgLen = 25;
   localparam int NumRuns = 4;
   // Load, run at three cycles per instruction and readback, five times over
   localparam int CycleLimit = NumRuns * 5 *
      (ProgLen * 5 + 2 * (`PROC_NUM_REGS + `PROC_DMEM_DEPTH) + 31);

   logic        clk, rstN, psel, penable, pwrite, pready, pslverr;
   logic [11:0] paddr;
   logic [31:0] pwdata, prdata, rdData, rngState;
   logic [15:0] prog [ProgLen];
   int          errors, checks, cycles;

   proc i_proc (
      .clk(clk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
   );

   procChecker chk (
      .clk(clk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .errors(errors), .checks(checks)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Setup cycle, then access cycle
   task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apbRead(input logic [11:0] addr, output logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      data = prdata;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   // Kind 0 ALU only, 2 branch and dependency dense, others mixed with LD and ST
   task automatic makeProgram(input int kind);
      logic [31:0] r;
      logic [3:0]  opc;
      logic [5:0]  low;
      logic [2:0]  rd, rs;
      for (int i = 0; i < ProgLen - 1; i++) begin
         rngState = xorshift(rngState);
         r   = rngState;
         rd  = r[2:0];
         rs  = r[5:3];
         low = r[11:6];
         case (kind)
            0: begin
               case (r[14:12])
                  3'd0, 3'd5: opc = opAdd;
                  3'd1, 3'd6: opc = opSub;
                  3'd2, 3'd7: opc = opAnd;
                  3'd3: opc = opXor;
                  default: opc = opAddi;
               endcase
            end
            2: begin
               // Four registers only, so most instructions wait on a recent one
               rd  = {1'b0, r[1:0]};
               rs  = {1'b0, r[4:3]};
               low = {1'b0, r[7:6], r[10:8]};
               case (r[14:12])
                  3'd0, 3'd1, 3'd2: opc = opBeqz;
                  3'd3: opc = opAdd;
                  3'd4: opc = opSub;
                  3'd5: opc = opXor;
                  3'd6: opc = opAddi;
                  default: opc = opLd;
               endcase
            end
            default: begin
               case (r[14:12])
                  3'd0: opc = opAdd;
                  3'd1: opc = opSub;
                  3'd2: opc = r[15] ? opXor : opAnd;
                  3'd3: opc = opAddi;
                  3'd4, 3'd5: opc = opLd;
                  3'd6: opc = opSt;
                  default: opc = r[15] ? opBeqz : (r[16] ? 4'd12 : opNop);
               endcase
            end
         endcase
         if (opc == opBeqz) begin
            // Forward by at most 5, never past the closing HALT
            low = 6'(r[18:16] % 3'd6);
            if (int'(low) > ProgLen - 2 - i) begin
               low = 6'(ProgLen - 2 - i);
            end
         end
         prog[i] = {opc, rd, rs, low};
      end
      prog[ProgLen - 1] = {opHalt, 12'd0};
   endtask

   task automatic loadProgram();
      for (int i = 0; i < ProgLen; i++) begin
         apbWrite(`PROC_BASE_IMEM + 12'(4 * i), {16'd0, prog[i]});
      end
   endtask

   task automatic waitHalted();
      logic [31:0] st;
      st = '0;
      while (!st[0]) begin
         apbRead(`PROC_ADDR_STATUS, st);
      end
   endtask

   task automatic readState(input logic withMem);
      apbRead(`PROC_ADDR_RETIRED, rdData);
      for (int i = 0; i < `PROC_NUM_REGS; i++) begin
         apbRead(`PROC_BASE_REGS + 12'(4 * i), rdData);
      end
      if (withMem) begin
         for (int i = 0; i < `PROC_DMEM_DEPTH; i++) begin
            apbRead(`PROC_BASE_DMEM + 12'(4 * i), rdData);
         end
      end
   endtask

   initial begin
      cycles = 0;
      while (cycles < CycleLimit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the test sequence did not finish within %0d cycles", CycleLimit);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      rstN     = 1'b0;
      rngState = 32'h1547a36d;
      repeat (3) @(posedge clk);
      rstN <= 1'b1;
      apbRead(`PROC_ADDR_CTRL, rdData);
      apbRead(`PROC_ADDR_STATUS, rdData);
      apbRead(`PROC_ADDR_RETIRED, rdData);
      // No reset between runs, state carries over
      for (int run = 0; run < NumRuns; run++) begin
         makeProgram(run);
         loadProgram();
         apbWrite(`PROC_ADDR_CTRL, 32'd1);
         if (run == NumRuns - 1) begin
            apbRead(`PROC_BASE_REGS + 12'h004, rdData);
            apbRead(`PROC_BASE_DMEM + 12'h008, rdData);
            apbWrite(`PROC_BASE_IMEM, 32'h0000_ffff);
         end
         waitHalted();
         readState(run != 0);
      end
      // Ignored write, then unmapped and unaligned addresses
      apbWrite(`PROC_ADDR_STATUS, 32'd3);
      apbRead(`PROC_ADDR_STATUS, rdData);
      apbRead(12'h240, rdData);
      apbRead(12'h302, rdData);
      apbWrite(12'h00c, 32'd1);
      apbRead(`PROC_ADDR_CTRL, rdData);
      repeat (2) @(posedge clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0 && checks > 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
